// ==== ip_rx.sv ====
`include "udp_rx_settings.svh"

module ip_rx import udp_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_enable,
    input  byte_t      rxd,
    input  logic       fs,
    input  logic       udp_fd,
    output logic       fd,
    output logic       udp_fs,
    output ipv4_addr_t src_ip,
    output len_t       drop_count
);

    ip_state_t state, next_state;

    len_t  cnt;          // byte index within the packet
    byte_t ver_ihl;
    byte_t proto;
    len_t  total_len;

    logic hdr_last;
    logic hdr_ok;
    logic skip_last;

    // last header byte is on rxd this cycle
    assign hdr_last  = (state == IP_HDR) && (cnt == len_t'(`IP_HDR_BYTES - 1));
    assign hdr_ok    = (ver_ihl == 8'h45) && (proto == byte_t'(`UDP_PROTO));
    assign skip_last = (cnt >= total_len - 16'd1);

    // udp_rx has to see fs while byte 19 is still on the bus
    assign udp_fs = (hdr_last && hdr_ok) || (state == IP_PASS);
    assign fd     = (state == IP_DONE);

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= IP_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            IP_IDLE: begin
                if (rx_enable) next_state = IP_WAIT;
            end
            IP_WAIT: begin
                if (fs) next_state = IP_HDR;
            end
            IP_HDR: begin
                if (hdr_last) begin
                    if (hdr_ok)
                        next_state = IP_PASS;
                    else if (total_len > len_t'(`IP_HDR_BYTES))
                        next_state = IP_SKIP;
                    else
                        next_state = IP_DONE;  // nothing left to skip
                end
            end
            IP_PASS: begin
                if (udp_fd) next_state = IP_DONE;
            end
            IP_SKIP: begin
                if (skip_last) next_state = IP_DONE;
            end
            IP_DONE: begin
                if (!fs) next_state = IP_WAIT;
            end
            default: next_state = IP_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cnt <= '0;
        else if (state == IP_WAIT)
            cnt <= '0;
        else if (state == IP_HDR || state == IP_SKIP)
            cnt <= cnt + 16'd1;
    end

    ////////////////////////////////////////
    // header fields
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ver_ihl   <= '0;
            total_len <= '0;
            proto     <= '0;
            src_ip    <= '0;
        end else if (state == IP_HDR) begin
            case (cnt)
                16'd0:  ver_ihl          <= rxd;
                16'd2:  total_len[15:8]  <= rxd;
                16'd3:  total_len[7:0]   <= rxd;
                16'd9:  proto            <= rxd;
                16'd12: src_ip[31:24]    <= rxd;
                16'd13: src_ip[23:16]    <= rxd;
                16'd14: src_ip[15:8]     <= rxd;
                16'd15: src_ip[7:0]      <= rxd;
                default: ;  // tos, id, flags, ttl, checksum, dst address
            endcase
        end
    end

    // one count per filtered packet, decided on byte 19
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            drop_count <= '0;
        else if (hdr_last && !hdr_ok)
            drop_count <= drop_count + 16'd1;
    end

endmodule

// ==== payload_fifo.sv ====
`include "udp_rx_settings.svh"

module payload_fifo import udp_rx_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  rd_en,
    output byte_t rd_data,
    output logic  empty,
    output logic  overflow
);

    localparam int AW = `UDP_FIFO_AW;

    byte_t mem [`UDP_FIFO_DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_wr;
    logic        do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;   // pop on empty is ignored

    // first word fall through
    assign rd_data = mem[rd_ptr[AW-1:0]];

    ////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr[AW-1:0]] <= wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wr_ptr <= '0;
        else if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_ptr <= '0;
        else if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
    end

    // sticky, a dropped byte means the datagram is incomplete
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            overflow <= 1'b0;
        else if (wr_en && full)
            overflow <= 1'b1;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the udp receive testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_udp_rx -f src.f -o sim_udp_rx || exit 1
out=$(./obj_dir/sim_udp_rx)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

// ==== src.f ====
+incdir+.
udp_rx_pkg.sv
ip_rx.sv
udp_rx.sv
payload_fifo.sv
udp_rx_top.sv
udp_rx_assertions.sv
tb_udp_rx.sv

// ==== tb_udp_rx.sv ====
`include "udp_rx_settings.svh"

module tb_udp_rx import udp_rx_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_PAY  = 40;
    localparam int OVF_PAY  = `UDP_FIFO_DEPTH + 6;
    localparam int N_HDR    = 6;
    localparam int N_MIX    = 20;
    localparam int N_FRAMES = N_HDR + 5 + 4 + 1 + N_MIX;
    // longest frame, 10 ns a byte, 4x for handshake and drain
    localparam int RUN_NS   = N_FRAMES * (`IP_HDR_BYTES + `UDP_HDR_BYTES + OVF_PAY) * 10 * 4;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    byte_t      rxd = '0;
    logic       fs = 1'b0;
    logic       rx_enable = 1'b0;
    logic       rd_en = 1'b0;
    logic       fd;
    ipv4_addr_t src_ip;
    port_t      src_port;
    port_t      dst_port;
    len_t       dlen;
    len_t       drop_count;
    byte_t      rd_data;
    logic       empty;
    logic       overflow;

    integer seed = 32'h65ec;
    byte_t  pkt[$];          // frame on its way to the DUT
    byte_t  exp_fifo[$];     // model of the payload buffer
    len_t   exp_drop = '0;
    logic   exp_ovf = 1'b0;  // sticky, like the DUT flag
    int     test_num = 0;
    int     test_errors = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    udp_rx_top DUT (.*);

    always #5 clk = ~clk;

    function automatic int rand_int(input int lo, input int hi);
        return lo + int'(($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    function automatic byte_t rand_byte();
        return byte_t'(rand_int(0, 255));
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d errors", test_num, name, test_errors);
        end
        test_errors = 0;
    endtask

    ////////////////////////////////////////
    // packet generator
    ////////////////////////////////////////

    task automatic push_word(input logic [15:0] w);
        pkt.push_back(w[15:8]);   // network order
        pkt.push_back(w[7:0]);
    endtask

    // 20 byte header, body_len bytes follow
    task automatic ip_header(input byte_t ver_ihl, input byte_t proto, input int body_len,
                             input ipv4_addr_t sip);
        int i;
        pkt.delete();
        pkt.push_back(ver_ihl);
        pkt.push_back(rand_byte());
        push_word(16'(`IP_HDR_BYTES + body_len));
        for (i = 0; i < 5; i++) pkt.push_back(rand_byte());  // id, flags, ttl
        pkt.push_back(proto);
        for (i = 0; i < 2; i++) pkt.push_back(rand_byte());  // checksum
        push_word(sip[31:16]);
        push_word(sip[15:0]);
        for (i = 0; i < 4; i++) pkt.push_back(rand_byte());  // destination
    endtask

    // raise fs, bytes back to back, then wait for fd
    task automatic send_frame();
        int i;
        int n;
        @(posedge clk);
        fs <= 1'b1;
        for (i = 0; i < pkt.size(); i++) begin
            @(posedge clk);
            rxd <= pkt[i];
        end
        n = 0;
        @(negedge clk);
        while (!fd && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!fd) report_error("fd did not rise after the frame was sent");
    endtask

    task automatic release_frame();
        int n;
        @(posedge clk);
        fs  <= 1'b0;
        rxd <= '0;
        n = 0;
        @(negedge clk);
        while (fd && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (fd) report_error("fd stayed high after fs fell");
    endtask

    // pop until empty, each byte against the model
    task automatic drain();
        int count;
        int want;
        want = exp_fifo.size();
        count = 0;
        @(negedge clk);
        while (!empty && count <= `UDP_FIFO_DEPTH) begin
            if (exp_fifo.size() == 0)
                report_error("the FIFO returned a byte that the model does not hold");
            else
                check("rd_data", 32'(rd_data), 32'(exp_fifo.pop_front()));
            @(posedge clk);
            rd_en <= 1'b1;
            @(posedge clk);
            rd_en <= 1'b0;
            @(negedge clk);
            count++;
        end
        check("popped bytes", count, want);
        exp_fifo.delete();
    endtask

    task automatic udp_datagram(input int pay_len);
        ipv4_addr_t sip;
        port_t      sp;
        port_t      dp;
        byte_t      b;
        int         i;
        sip = ipv4_addr_t'($random(seed));
        sp  = port_t'(rand_int(0, 65535));
        dp  = port_t'(rand_int(0, 65535));
        ip_header(8'h45, 8'(`UDP_PROTO), `UDP_HDR_BYTES + pay_len, sip);
        push_word(sp);
        push_word(dp);
        push_word(16'(`UDP_HDR_BYTES + pay_len));
        push_word(16'(rand_int(0, 65535)));
        for (i = 0; i < pay_len; i++) begin
            b = rand_byte();
            pkt.push_back(b);
            // full buffer drops the byte
            if (exp_fifo.size() < `UDP_FIFO_DEPTH)
                exp_fifo.push_back(b);
            else
                exp_ovf = 1'b1;
        end
        send_frame();
        check("src_port", 32'(src_port), 32'(sp));
        check("dst_port", 32'(dst_port), 32'(dp));
        check("dlen", 32'(dlen), pay_len);
        check("src_ip", src_ip, sip);
        check("overflow", 32'(overflow), 32'(exp_ovf));
        release_frame();
        drain();
    endtask

    // bad_ver picks a wrong version/ihl byte, else a wrong protocol
    task automatic filtered_packet(input bit bad_ver, input int body_len);
        byte_t ver_ihl;
        byte_t proto;
        int    i;
        ver_ihl = 8'h45;
        proto   = 8'(`UDP_PROTO);
        if (bad_ver) begin
            while (ver_ihl == 8'h45) ver_ihl = rand_byte();
        end else begin
            while (proto == 8'(`UDP_PROTO)) proto = rand_byte();
        end
        ip_header(ver_ihl, proto, body_len, ipv4_addr_t'($random(seed)));
        for (i = 0; i < body_len; i++) pkt.push_back(rand_byte());
        exp_drop++;
        send_frame();
        check("drop_count", 32'(drop_count), 32'(exp_drop));
        check("empty", 32'(empty), 1);
        release_frame();
    endtask

    initial begin
        int i;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("fd", 32'(fd), 0);
        check("empty", 32'(empty), 1);
        check("overflow", 32'(overflow), 0);
        check("drop_count", 32'(drop_count), 0);
        end_test("reset state");

        @(posedge clk);
        rx_enable <= 1'b1;
        repeat (2) @(posedge clk);

        for (i = 0; i < N_HDR; i++) udp_datagram(rand_int(1, MAX_PAY));
        end_test("header fields");

        udp_datagram(1);
        udp_datagram(MAX_PAY);
        for (i = 0; i < 3; i++) udp_datagram(rand_int(1, MAX_PAY));
        end_test("payload through the FIFO");

        filtered_packet(1'b0, 0);      // header only, nothing to skip
        filtered_packet(1'b0, rand_int(8, 48));
        filtered_packet(1'b1, rand_int(8, 48));
        filtered_packet(1'b1, rand_int(8, 48));
        end_test("filtered packets");

        udp_datagram(OVF_PAY);
        end_test("overflow");

        for (i = 0; i < N_MIX; i++) begin
            if (rand_int(0, 2) == 0)
                filtered_packet(rand_int(0, 1) == 1, rand_int(0, 48));
            else
                udp_datagram(rand_int(1, MAX_PAY));
        end
        check("drop_count", 32'(drop_count), 32'(exp_drop));
        check("empty", 32'(empty), 1);
        end_test("mixed sequence");

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(RUN_NS);
        $display("watchdog: the run did not finish within %0d ns", RUN_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== udp_rx.sv ====
`include "udp_rx_settings.svh"

module udp_rx import udp_rx_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rx_enable,
    input  byte_t rxd,
    input  logic  fs,
    output logic  fd,
    output len_t  dlen,
    output port_t src_port,
    output port_t dst_port,
    output logic  wr_en,
    output byte_t wr_data
);

    udp_state_t state, next_state;

    len_t udp_len;   // length field, header included
    len_t cnt;       // payload bytes taken so far

    assign fd = (state == UDP_DONE);

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= UDP_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            UDP_IDLE: begin
                if (rx_enable) next_state = UDP_WAIT;
            end
            UDP_WAIT: begin
                if (fs) next_state = UDP_HD0;
            end
            UDP_HD0: next_state = UDP_HD1;
            UDP_HD1: next_state = UDP_HD2;
            UDP_HD2: next_state = UDP_HD3;
            UDP_HD3: next_state = UDP_HD4;
            UDP_HD4: next_state = UDP_HD5;
            UDP_HD5: next_state = UDP_HD6;
            UDP_HD6: next_state = UDP_HD7;
            UDP_HD7: begin
                // empty datagram goes straight to done
                if (dlen == '0)
                    next_state = UDP_DONE;
                else
                    next_state = UDP_WORK;
            end
            UDP_WORK: begin
                if (cnt >= dlen - 16'd1) next_state = UDP_DONE;
            end
            UDP_DONE: begin
                if (!fs) next_state = UDP_WAIT;
            end
            default: next_state = UDP_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cnt <= '0;
        else if (state == UDP_WAIT)
            cnt <= '0;
        else if (state == UDP_WORK)
            cnt <= cnt + 16'd1;
    end

    ////////////////////////////////////////
    // header fields
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_port <= '0;
            dst_port <= '0;
            udp_len  <= '0;
            dlen     <= '0;
        end else begin
            case (state)
                UDP_HD0: src_port[15:8] <= rxd;
                UDP_HD1: src_port[7:0]  <= rxd;
                UDP_HD2: dst_port[15:8] <= rxd;
                UDP_HD3: dst_port[7:0]  <= rxd;
                UDP_HD4: udp_len[15:8]  <= rxd;
                UDP_HD5: udp_len[7:0]   <= rxd;
                UDP_HD6: begin
                    if (udp_len < len_t'(`UDP_HDR_BYTES))
                        dlen <= '0;     // malformed length
                    else
                        dlen <= udp_len - len_t'(`UDP_HDR_BYTES);
                end
                default: ;  // HD7 is the checksum low byte
            endcase
        end
    end

    // payload write, one cycle behind rxd
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wr_en <= 1'b0;
        else
            wr_en <= (state == UDP_WORK);
    end

    always_ff @(posedge clk) begin
        wr_data <= rxd;
    end

endmodule

// ==== udp_rx_assertions.sv ====
module udp_rx_assertions (
    input logic clk,
    input logic rst,
    input logic fs,
    input logic fd,
    input logic udp_fs,
    input logic udp_fd,
    input logic wr_en
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////
    // frame handshake
    ////////////////////////////////////////

    fd_needs_fs: assert property (@(posedge clk) disable iff (rst) $rose(fd) |-> fs)
        else $error("fd rose while fs was low");

    // ip_rx lets go of udp_rx only once it reported done
    udp_fs_after_fd: assert property (@(posedge clk) disable iff (rst)
        $fell(udp_fs) |-> $past(udp_fd))
        else $error("udp_fs fell before udp_fd was seen");

    wr_inside_frame: assert property (@(posedge clk) disable iff (rst) wr_en |-> udp_fs)
        else $error("FIFO write outside the udp frame");

    // whole payload is in the buffer by the time the frame is reported done
    write_before_fd: assert property (@(posedge clk) disable iff (rst) fd |-> !wr_en)
        else $error("FIFO write while fd was high");

endmodule

bind udp_rx_top udp_rx_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .fs        (fs),
    .fd        (fd),
    .udp_fs    (udp_fs),
    .udp_fd    (udp_fd),
    .wr_en     (wr_en)
);

// ==== udp_rx_pkg.sv ====
package udp_rx_pkg;

    typedef logic [7:0]  byte_t;       // one stream byte
    typedef logic [15:0] port_t;       // udp port number
    typedef logic [15:0] len_t;        // byte count
    typedef logic [31:0] ipv4_addr_t;

    // ipv4 header parser
    typedef enum logic [2:0] {
        IP_IDLE,
        IP_WAIT,
        IP_HDR,
        IP_PASS,    // udp_rx owns the stream
        IP_SKIP,    // dropped packet, run out to total length
        IP_DONE
    } ip_state_t;

    // udp header parser, one state per header byte
    typedef enum logic [3:0] {
        UDP_IDLE,
        UDP_WAIT,
        UDP_HD0,
        UDP_HD1,
        UDP_HD2,
        UDP_HD3,
        UDP_HD4,
        UDP_HD5,
        UDP_HD6,
        UDP_HD7,
        UDP_WORK,
        UDP_DONE
    } udp_state_t;

endpackage

// ==== udp_rx_settings.svh ====
`ifndef UDP_RX_SETTINGS_SVH
`define UDP_RX_SETTINGS_SVH

////////////////////////////////////////
// payload buffer
////////////////////////////////////////

`define UDP_FIFO_DEPTH 64     // any power of two
`define UDP_FIFO_AW    6      // log2 of the depth

////////////////////////////////////////
// protocol constants
////////////////////////////////////////

// fixed header, no options
`define IP_HDR_BYTES   20

`define UDP_HDR_BYTES  8
`define UDP_PROTO      17     // ipv4 protocol field for udp

`endif

// ==== udp_rx_top.sv ====
module udp_rx_top import udp_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // ipv4 byte stream
    input  byte_t      rxd,
    input  logic       fs,
    output logic       fd,
    input  logic       rx_enable,

    // header fields
    output ipv4_addr_t src_ip,
    output port_t      src_port,
    output port_t      dst_port,
    output len_t       dlen,
    output len_t       drop_count,

    // payload read side
    input  logic       rd_en,
    output byte_t      rd_data,
    output logic       empty,
    output logic       overflow
);

    logic  udp_fs;     // ip_rx to udp_rx frame select
    logic  udp_fd;
    logic  wr_en;
    byte_t wr_data;

    ip_rx u_ip_rx (
        .clk        (clk),
        .rst        (rst),
        .rx_enable  (rx_enable),
        .rxd        (rxd),
        .fs         (fs),
        .udp_fd     (udp_fd),
        .fd         (fd),
        .udp_fs     (udp_fs),
        .src_ip     (src_ip),
        .drop_count (drop_count)
    );

    // rxd is shared, udp_rx only listens while udp_fs is up
    udp_rx u_udp_rx (
        .clk        (clk),
        .rst        (rst),
        .rx_enable  (rx_enable),
        .rxd        (rxd),
        .fs         (udp_fs),
        .fd         (udp_fd),
        .dlen       (dlen),
        .src_port   (src_port),
        .dst_port   (dst_port),
        .wr_en      (wr_en),
        .wr_data    (wr_data)
    );

    payload_fifo u_payload_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .empty      (empty),
        .overflow   (overflow)
    );

endmodule
